/* common/aud_pkg.sv */
`default_nettype none

package aud_pkg;

	localparam int SAMPLE_W  = 16;
	localparam int SRAM_AW   = 20;
	localparam int SPEED_W   = 4;
	localparam int COUNT_W   = 24;
	localparam int SEND_BITS = 16;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [SRAM_AW-1:0]         sram_addr_t;
	// legal range 1 to 8
	typedef logic [SPEED_W-1:0]         speed_t;
	typedef logic [COUNT_W-1:0]         count_t;

	typedef enum logic [1:0] {
		MODE_FAST        = 2'd0,
		MODE_SLOW_HOLD   = 2'd1,
		MODE_SLOW_LINEAR = 2'd2
	} play_mode_e;

	// slow states serve both hold and linear, split by mode
	typedef enum logic [2:0] {
		S_IDLE       = 3'd0,
		S_FAST_FETCH = 3'd1,
		S_FAST_SENT  = 3'd2,
		S_SLOW_FETCH = 3'd3,
		S_SLOW_SENT  = 3'd4
	} dsp_state_e;

	typedef struct packed {
		logic       start;
		logic       stop;
		logic       pause;
		play_mode_e mode;
		speed_t     speed;
		count_t     record_len;
	} play_ctrl_t;

	typedef struct packed {
		logic       we;
		sram_addr_t addr;
		sample_t    data;
	} sram_wr_t;

endpackage

`default_nettype wire

/* verilog/aud_sram.sv */
`timescale 1ns/10ps
`default_nettype none

module aud_sram (
	input  wire                  i_clk,
	input  aud_pkg::sram_wr_t    i_wr,
	input  aud_pkg::sram_addr_t  i_rd_addr,
	output aud_pkg::sample_t     o_rd_data
);

	aud_pkg::sample_t mem [0:2**aud_pkg::SRAM_AW-1];

	// load port from the recorder side
	always_ff @(posedge i_clk) begin
		if (i_wr.we) begin
			mem[i_wr.addr] <= i_wr.data;
		end
	end

	// asynchronous read, data valid in the same cycle
	assign o_rd_data = mem[i_rd_addr];

endmodule

`default_nettype wire

/* verilog/aud_player.sv */
`timescale 1ns/10ps
`default_nettype none

module aud_player (
	input  wire               i_clk,
	input  wire               i_rst_n,
	input  wire               i_en,
	input  aud_pkg::sample_t  i_sample,
	output logic              o_dacdat,
	output logic              o_frame,
	output logic              o_sent_finish
);

	typedef enum logic [1:0] {
		P_IDLE     = 2'd0,
		P_SHIFT    = 2'd1,
		P_DONE     = 2'd2,
		P_WAIT_LOW = 2'd3
	} player_state_e;

	player_state_e                            state_r;
	logic [$clog2(aud_pkg::SEND_BITS)-1:0]    bit_cnt_r;
	logic                                     dropped_r;
	aud_pkg::sample_t                         shift_r;

	assign o_frame       = state_r == P_SHIFT;
	assign o_dacdat      = o_frame & shift_r[aud_pkg::SAMPLE_W-1];
	// a frame whose enable went away (stop) does not report
	assign o_sent_finish = state_r == P_DONE && !dropped_r;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r   <= P_IDLE;
			bit_cnt_r <= '0;
			dropped_r <= 1'b0;
		end else begin
			case (state_r)
				P_IDLE: begin
					if (i_en) begin
						bit_cnt_r <= '0;
						dropped_r <= 1'b0;
						state_r   <= P_SHIFT;
					end
				end
				P_SHIFT: begin
					if (!i_en) begin
						dropped_r <= 1'b1;
					end
					bit_cnt_r <= bit_cnt_r + 1'b1;
					if (bit_cnt_r == aud_pkg::SEND_BITS - 1) begin
						state_r <= P_DONE;
					end
				end
				P_DONE: begin
					if (dropped_r) begin
						state_r <= P_IDLE;
					end else begin
						state_r <= P_WAIT_LOW;
					end
				end
				default: begin
					// no restart until enable is seen low
					if (!i_en) begin
						state_r <= P_IDLE;
					end
				end
			endcase
		end
	end

	// msb first
	always_ff @(posedge i_clk) begin
		if (state_r == P_IDLE && i_en) begin
			shift_r <= i_sample;
		end else if (state_r == P_SHIFT) begin
			shift_r <= {shift_r[aud_pkg::SAMPLE_W-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* aud_dsp/aud_dsp.sv */
`timescale 1ns/10ps
`default_nettype none

module aud_dsp (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  aud_pkg::play_ctrl_t  i_ctrl,
	input  wire                  i_daclrck,
	input  wire                  i_sent_finish,
	input  aud_pkg::sample_t     i_sram_data,
	output aud_pkg::sram_addr_t  o_sram_addr,
	output aud_pkg::sample_t     o_dac_sample,
	output logic                 o_player_en,
	output logic                 o_finish
);

	aud_pkg::dsp_state_e state_r, state_w;
	aud_pkg::play_mode_e mode_r, mode_w;
	aud_pkg::speed_t     speed_r, speed_w;
	aud_pkg::count_t     total_r, total_w;
	aud_pkg::count_t     sent_cnt_r, sent_cnt_w;
	aud_pkg::sram_addr_t addr_r, addr_w;
	aud_pkg::speed_t     interp_cnt_r, interp_cnt_w;
	logic [1:0]          fetch_cnt_r, fetch_cnt_w;
	logic                player_en_r, player_en_w;
	logic                finish_r, finish_w;

	aud_pkg::sample_t    dac_sample_r, dac_sample_w;
	aud_pkg::sample_t    sram1_r, sram1_w;
	aud_pkg::sample_t    sram2_r, sram2_w;

	aud_pkg::count_t     len_m1;
	aud_pkg::count_t     speed_ext;
	aud_pkg::sample_t    diff;
	aud_pkg::sample_t    speed_div;
	aud_pkg::sample_t    step;
	logic                en_allowed;
	logic                group_end;

	assign o_sram_addr  = addr_r;
	assign o_dac_sample = dac_sample_r;
	assign o_player_en  = player_en_r;
	assign o_finish     = finish_r;

	// expected output count comes straight from the controls at start
	assign len_m1    = i_ctrl.record_len - 1'b1;
	assign speed_ext = aud_pkg::count_t'(i_ctrl.speed);

	// truncating signed step between neighbours
	assign diff      = sram2_r - sram1_r;
	assign speed_div = aud_pkg::sample_t'(speed_r);
	assign step      = diff / speed_div;

	assign en_allowed = i_daclrck && !i_ctrl.pause;
	// last repeat of the current group
	assign group_end  = aud_pkg::speed_t'(interp_cnt_r + 1'b1) == speed_r;

	always_comb begin
		state_w      = state_r;
		mode_w       = mode_r;
		speed_w      = speed_r;
		total_w      = total_r;
		sent_cnt_w   = sent_cnt_r;
		addr_w       = addr_r;
		interp_cnt_w = interp_cnt_r;
		fetch_cnt_w  = fetch_cnt_r;
		player_en_w  = player_en_r;
		finish_w     = 1'b0;
		dac_sample_w = dac_sample_r;
		sram1_w      = sram1_r;
		sram2_w      = sram2_r;

		case (state_r)
			aud_pkg::S_IDLE: begin
				player_en_w = 1'b0;
				if (i_ctrl.start) begin
					mode_w       = i_ctrl.mode;
					speed_w      = i_ctrl.speed;
					sent_cnt_w   = '0;
					addr_w       = '0;
					interp_cnt_w = '0;
					fetch_cnt_w  = '0;
					if (i_ctrl.mode == aud_pkg::MODE_FAST) begin
						total_w = len_m1 / speed_ext + 1'b1;
						state_w = aud_pkg::S_FAST_FETCH;
					end else begin
						total_w = len_m1 * speed_ext + 1'b1;
						state_w = aud_pkg::S_SLOW_FETCH;
					end
				end
			end

			aud_pkg::S_FAST_FETCH: begin
				dac_sample_w = i_sram_data;
				addr_w       = addr_r + aud_pkg::sram_addr_t'(speed_r);
				sent_cnt_w   = sent_cnt_r + 1'b1;
				player_en_w  = en_allowed;
				state_w      = aud_pkg::S_FAST_SENT;
			end

			aud_pkg::S_SLOW_FETCH: begin
				fetch_cnt_w = fetch_cnt_r + 1'b1;
				case (fetch_cnt_r)
					2'd0: begin
						// sample k
						sram1_w = i_sram_data;
						addr_w  = addr_r + 1'b1;
					end
					2'd1: begin
						// sample k+1, step back unless the group is done
						sram2_w = i_sram_data;
						if (!group_end) begin
							addr_w = addr_r - 1'b1;
						end
					end
					default: begin
						if (mode_r == aud_pkg::MODE_SLOW_LINEAR && interp_cnt_r != '0) begin
							dac_sample_w = dac_sample_r + step;
						end else begin
							dac_sample_w = sram1_r;
						end
						if (group_end) begin
							interp_cnt_w = '0;
						end else begin
							interp_cnt_w = interp_cnt_r + 1'b1;
						end
						fetch_cnt_w = '0;
						sent_cnt_w  = sent_cnt_r + 1'b1;
						player_en_w = en_allowed;
						state_w     = aud_pkg::S_SLOW_SENT;
					end
				endcase
			end

			aud_pkg::S_FAST_SENT, aud_pkg::S_SLOW_SENT: begin
				if (i_sent_finish) begin
					player_en_w = 1'b0;
					if (sent_cnt_r == total_r) begin
						state_w  = aud_pkg::S_IDLE;
						finish_w = 1'b1;
					end else if (state_r == aud_pkg::S_FAST_SENT) begin
						state_w = aud_pkg::S_FAST_FETCH;
					end else begin
						state_w = aud_pkg::S_SLOW_FETCH;
					end
				end else if (!player_en_r) begin
					// held off by pause or low lrck
					player_en_w = en_allowed;
				end
			end

			default: begin
				state_w     = aud_pkg::S_IDLE;
				player_en_w = 1'b0;
			end
		endcase

		if (i_ctrl.stop) begin
			state_w     = aud_pkg::S_IDLE;
			player_en_w = 1'b0;
			finish_w    = 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r      <= aud_pkg::S_IDLE;
			mode_r       <= aud_pkg::MODE_FAST;
			speed_r      <= '0;
			total_r      <= '0;
			sent_cnt_r   <= '0;
			addr_r       <= '0;
			interp_cnt_r <= '0;
			fetch_cnt_r  <= '0;
			player_en_r  <= 1'b0;
			finish_r     <= 1'b0;
		end else begin
			state_r      <= state_w;
			mode_r       <= mode_w;
			speed_r      <= speed_w;
			total_r      <= total_w;
			sent_cnt_r   <= sent_cnt_w;
			addr_r       <= addr_w;
			interp_cnt_r <= interp_cnt_w;
			fetch_cnt_r  <= fetch_cnt_w;
			player_en_r  <= player_en_w;
			finish_r     <= finish_w;
		end
	end

	always_ff @(posedge i_clk) begin
		dac_sample_r <= dac_sample_w;
		sram1_r      <= sram1_w;
		sram2_r      <= sram2_w;
	end

endmodule

`default_nettype wire

/* verilog/aud_playback_top.sv */
`timescale 1ns/10ps
`default_nettype none

module aud_playback_top (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  aud_pkg::play_ctrl_t  i_ctrl,
	input  wire                  i_daclrck,
	input  aud_pkg::sram_wr_t    i_sram_wr,
	output logic                 o_dacdat,
	output logic                 o_dac_frame,
	output logic                 o_finish
);

	aud_pkg::sram_addr_t sram_addr;
	aud_pkg::sample_t    sram_data;
	aud_pkg::sample_t    dac_sample;
	logic                player_en;
	logic                sent_finish;

	aud_dsp dsp0 (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_ctrl        (i_ctrl),
		.i_daclrck     (i_daclrck),
		.i_sent_finish (sent_finish),
		.i_sram_data   (sram_data),
		.o_sram_addr   (sram_addr),
		.o_dac_sample  (dac_sample),
		.o_player_en   (player_en),
		.o_finish      (o_finish)
	);

	aud_sram sram0 (
		.i_clk     (i_clk),
		.i_wr      (i_sram_wr),
		.i_rd_addr (sram_addr),
		.o_rd_data (sram_data)
	);

	aud_player player0 (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_en          (player_en),
		.i_sample      (dac_sample),
		.o_dacdat      (o_dacdat),
		.o_frame       (o_dac_frame),
		.o_sent_finish (sent_finish)
	);

endmodule

`default_nettype wire

/* verification/aud_tb_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module aud_tb_sva (
	input wire                 i_clk,
	input wire                 i_rst_n,
	input aud_pkg::play_ctrl_t i_ctrl,
	input wire                 o_dac_frame,
	input wire                 o_finish
);

	logic [4:0] frame_len;

	// cycles the current frame has been high
	always_ff @(posedge i_clk) begin
		if (!i_rst_n || !o_dac_frame) begin
			frame_len <= '0;
		end else begin
			frame_len <= frame_len + 1'b1;
		end
	end

	finish_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_finish |=> !o_finish)
		else $error("o_finish stayed high for more than one cycle");

	frame_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$fell(o_dac_frame) |-> frame_len == 5'd16)
		else $error("o_dac_frame ended after %0d cycles", frame_len);

	frame_not_long: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_dac_frame |-> frame_len < 5'd16)
		else $error("o_dac_frame ran past 16 cycles");

	// enable is registered, so a start two cycles later still reflects the old pause
	no_start_paused: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(o_dac_frame) |-> !$past(i_ctrl.pause, 2))
		else $error("frame started while pause was high");

	frame_low_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_dac_frame)
		else $error("o_dac_frame high after reset");

endmodule

`default_nettype wire

/* verification/aud_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module aud_tb;

	localparam int CLK_PERIOD = 8;
	// 122 worst-case frames at 20 cycles each, plus stall windows and idle gaps
	localparam int WATCHDOG_CYCLES = 122 * 20 + 2000;

	logic                i_clk;
	logic                i_rst_n;
	aud_pkg::play_ctrl_t i_ctrl;
	logic                i_daclrck;
	aud_pkg::sram_wr_t   i_sram_wr;
	logic                o_dacdat;
	logic                o_dac_frame;
	logic                o_finish;

	aud_pkg::sample_t ref_mem [0:63];
	aud_pkg::sample_t rx_q[$];
	aud_pkg::sample_t exp_q[$];
	aud_pkg::sample_t rx_shift;
	int               bit_cnt, start_cnt, finish_cnt, errors, checks;
	bit               frame_d1, pause_d1, pause_d2;
	bit               lrck_d1 = 1'b1;
	bit               lrck_d2 = 1'b1;
	logic [31:0]      lcg_state;

	aud_playback_top dut0 (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_ctrl      (i_ctrl),
		.i_daclrck   (i_daclrck),
		.i_sram_wr   (i_sram_wr),
		.o_dacdat    (o_dacdat),
		.o_dac_frame (o_dac_frame),
		.o_finish    (o_finish)
	);

	bind aud_playback_top aud_tb_sva sva0 (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_ctrl      (i_ctrl),
		.o_dac_frame (o_dac_frame),
		.o_finish    (o_finish)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// deserialize frames mid-cycle, a frame may only start two cycles after enable was allowed
	always @(negedge i_clk) begin
		if (o_dac_frame) begin
			rx_shift = {rx_shift[aud_pkg::SAMPLE_W-2:0], o_dacdat};
			bit_cnt++;
			if (bit_cnt == aud_pkg::SEND_BITS) begin
				rx_q.push_back(rx_shift);
				bit_cnt = 0;
			end
			if (!frame_d1) begin
				start_cnt++;
				if (pause_d2 || !lrck_d2) begin
					errors++;
					$display("a frame started while paused or with lrck low at %0t", $time);
				end
			end
		end else if (bit_cnt != 0) begin
			errors++;
			$display("a frame ended after only %0d bits at %0t", bit_cnt, $time);
			bit_cnt = 0;
		end
		if (o_finish) begin
			finish_cnt++;
		end
		frame_d1 = o_dac_frame;
		pause_d2 = pause_d1;
		pause_d1 = i_ctrl.pause;
		lrck_d2  = lrck_d1;
		lrck_d1  = i_daclrck;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_sample(input string name, input aud_pkg::sample_t got,
			input aud_pkg::sample_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input aud_pkg::count_t got,
			input aud_pkg::count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_finish(input string name, input bit got, input bit exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic step_cycles(input int n);
		repeat (n) @(posedge i_clk);
		#1;
	endtask

	task automatic write_word(input int addr, input aud_pkg::sample_t data);
		i_sram_wr.we   = 1'b1;
		i_sram_wr.addr = aud_pkg::sram_addr_t'(addr);
		i_sram_wr.data = data;
		ref_mem[addr]  = data;
		step_cycles(1);
		i_sram_wr.we   = 1'b0;
	endtask

	// one word past the record so the slow fetch of k+1 reads defined data
	task automatic load_samples(input int n);
		for (int i = 0; i <= n; i++) begin
			lcg_state = lcg_next(lcg_state);
			write_word(i, aud_pkg::sample_t'(lcg_state[31:16]));
		end
	endtask

	task automatic expect_fast(input int len, input int speed);
		exp_q.delete();
		for (int i = 0; i < len; i += speed) begin
			exp_q.push_back(ref_mem[i]);
		end
	endtask

	// step is the wrapped neighbour difference over speed, truncated toward zero
	task automatic expect_slow(input int len, input int speed, input bit linear);
		aud_pkg::sample_t diff, step, acc;
		exp_q.delete();
		for (int k = 0; k < len - 1; k++) begin
			diff = ref_mem[k + 1] - ref_mem[k];
			step = aud_pkg::sample_t'(diff / speed);
			acc  = ref_mem[k];
			for (int j = 0; j < speed; j++) begin
				exp_q.push_back(acc);
				acc = linear ? aud_pkg::sample_t'(acc + step) : acc;
			end
		end
		exp_q.push_back(ref_mem[len - 1]);
	endtask

	task automatic start_play(input aud_pkg::play_mode_e mode, input int speed, input int len);
		rx_q.delete();
		i_ctrl.mode       = mode;
		i_ctrl.speed      = aud_pkg::speed_t'(speed);
		i_ctrl.record_len = aud_pkg::count_t'(len);
		i_ctrl.start      = 1'b1;
		step_cycles(1);
		i_ctrl.start      = 1'b0;
	endtask

	task automatic wait_frames(input int n);
		int cycles;
		cycles = 0;
		while (rx_q.size() < n && cycles < 2000) begin
			step_cycles(1);
			cycles++;
		end
		if (rx_q.size() < n) begin
			errors++;
			$display("only %0d of %0d frames arrived in time", rx_q.size(), n);
		end
	endtask

	task automatic wait_finish(input int base);
		int cycles;
		cycles = 0;
		while (finish_cnt == base && cycles < 3000) begin
			step_cycles(1);
			cycles++;
		end
		if (finish_cnt == base) begin
			errors++;
			$display("o_finish did not pulse within %0d cycles", cycles);
		end
		// catch any stray frame after the end
		step_cycles(40);
		check_finish("o_finish single pulse", finish_cnt == base + 1, 1'b1);
	endtask

	task automatic compare_frames(input string tag);
		check_count({tag, " o_dac_frame count"}, aud_pkg::count_t'(rx_q.size()),
			aud_pkg::count_t'(exp_q.size()));
		for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
			check_sample($sformatf("%s o_dacdat frame %0d", tag, i), rx_q[i], exp_q[i]);
		end
	endtask

	task automatic play_and_check(input string tag, input aud_pkg::play_mode_e mode,
			input int speed, input int len);
		int base;
		base = finish_cnt;
		start_play(mode, speed, len);
		wait_finish(base);
		compare_frames(tag);
	endtask

	task automatic test_fast();
		load_samples(20);
		expect_fast(20, 1);
		play_and_check("fast s1", aud_pkg::MODE_FAST, 1, 20);
		expect_fast(20, 3);
		play_and_check("fast s3", aud_pkg::MODE_FAST, 3, 20);
	endtask

	task automatic test_slow_hold();
		load_samples(8);
		expect_slow(8, 4, 1'b0);
		play_and_check("hold s4", aud_pkg::MODE_SLOW_HOLD, 4, 8);
	endtask

	task automatic test_slow_linear();
		load_samples(10);
		// full-scale swings, some of which wrap
		write_word(2, 16'sh7fff);
		write_word(3, 16'sh8001);
		write_word(5, 16'sh8000);
		write_word(6, 16'sh7ff0);
		write_word(7, 16'sh4000);
		expect_slow(10, 3, 1'b1);
		play_and_check("linear s3", aud_pkg::MODE_SLOW_LINEAR, 3, 10);
	endtask

	task automatic test_stall();
		int base, snap;
		load_samples(24);
		expect_fast(24, 2);
		base = finish_cnt;
		start_play(aud_pkg::MODE_FAST, 2, 24);
		wait_frames(3);
		i_ctrl.pause = 1'b1;
		step_cycles(2);
		snap = start_cnt;
		step_cycles(60);
		check_count("o_dac_frame starts while paused", aud_pkg::count_t'(start_cnt - snap), '0);
		i_ctrl.pause = 1'b0;
		wait_frames(7);
		i_daclrck = 1'b0;
		step_cycles(2);
		snap = start_cnt;
		step_cycles(60);
		check_count("o_dac_frame starts with lrck low", aud_pkg::count_t'(start_cnt - snap), '0);
		i_daclrck = 1'b1;
		wait_finish(base);
		compare_frames("stall");
	endtask

	task automatic test_stop();
		int base, snap;
		load_samples(20);
		base = finish_cnt;
		start_play(aud_pkg::MODE_FAST, 1, 20);
		wait_frames(4);
		i_ctrl.stop = 1'b1;
		step_cycles(1);
		i_ctrl.stop = 1'b0;
		step_cycles(1);
		snap = start_cnt;
		step_cycles(60);
		check_count("o_dac_frame starts after stop", aud_pkg::count_t'(start_cnt - snap), '0);
		check_finish("o_finish on stop", finish_cnt == base + 1, 1'b1);
		for (int i = 0; i < rx_q.size(); i++) begin
			check_sample($sformatf("stop o_dacdat frame %0d", i), rx_q[i], ref_mem[i]);
		end
		expect_fast(6, 1);
		play_and_check("restart", aud_pkg::MODE_FAST, 1, 6);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		i_rst_n      = 1'b0;
		i_ctrl       = '0;
		i_ctrl.speed = 4'd1;
		i_daclrck    = 1'b1;
		i_sram_wr    = '0;
		lcg_state    = 32'h72c2;
		step_cycles(2);
		i_rst_n = 1'b1;
		step_cycles(2);
		test_fast();
		test_slow_hold();
		test_slow_linear();
		test_stall();
		test_stop();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
common/aud_pkg.sv
verilog/aud_sram.sv
verilog/aud_player.sv
aud_dsp/aud_dsp.sv
verilog/aud_playback_top.sv
verification/aud_tb_sva.sv
verification/aud_tb.sv

/* run.sh */
#!/bin/sh
# build and run the audio playback testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module aud_tb -f all.f -o aud_tb_sim \
	&& ./obj_dir/aud_tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
